/* include/cart_consts.svh */
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// MSU register window, CPU offset of the first register
`define CART_MSU_BASE          16'h2000

// read side
`define CART_MSU_REG_STATUS    3'd0
`define CART_MSU_REG_DATA      3'd1

// write side
`define CART_MSU_REG_SEEK0     3'd0
`define CART_MSU_REG_SEEK1     3'd1
`define CART_MSU_REG_SEEK2     3'd2
`define CART_MSU_REG_SEEK3     3'd3
`define CART_MSU_REG_TRACK_LO  3'd4
`define CART_MSU_REG_TRACK_HI  3'd5
`define CART_MSU_REG_VOLUME    3'd6

// "S-MSU1", read back at offsets 2..7
`define CART_MSU_ID_0          8'h53
`define CART_MSU_ID_1          8'h2d
`define CART_MSU_ID_2          8'h4d
`define CART_MSU_ID_3          8'h53
`define CART_MSU_ID_4          8'h55
`define CART_MSU_ID_5          8'h31

`define CART_MAP_HIROM_BIT     0

// lorom save ram banks
`define CART_LOROM_SRAM_FIRST  8'h70
`define CART_LOROM_SRAM_LAST   8'h7d

`define CART_STATUS_BUSY_BIT   7

`endif

/* hw/cart_bus_pkg.sv */
package cart_bus_pkg;

	// cpu side
	typedef logic [23:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// rom port, 16 bit wide, byte addressed
	typedef logic [23:0] rom_addr_t;
	typedef logic [15:0] rom_word_t;

	typedef logic [19:0] bsram_addr_t;

	typedef logic [7:0]  map_ctrl_t; // bit 0 selects hirom

endpackage

/* hw/msu_pkg.sv */
package msu_pkg;

	typedef logic [31:0] msu_addr_t; // byte position in the data file
	typedef logic [15:0] msu_track_t;
	typedef logic [7:0]  msu_volume_t;

	// four-phase fetch of one data byte
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_DROP
	} msu_fetch_t;

endpackage

/* hw/rom_mapper.sv */
`include "cart_consts.svh"

module rom_mapper (
	input  logic                      mclk,
	input  logic                      rst_n,

	input  cart_bus_pkg::cpu_addr_t   ca,
	input  logic                      cpurd_n,
	input  logic                      cpuwr_n,
	input  logic                      romsel_n,
	input  cart_bus_pkg::cpu_data_t   cpu_wdata,

	input  cart_bus_pkg::map_ctrl_t   map_ctrl,
	input  cart_bus_pkg::rom_addr_t   rom_mask,
	input  cart_bus_pkg::bsram_addr_t bsram_mask,

	output cart_bus_pkg::rom_addr_t   rom_addr,
	input  cart_bus_pkg::rom_word_t   rom_q,
	output logic                      rom_ce_n,
	output logic                      rom_oe_n,

	output cart_bus_pkg::bsram_addr_t bsram_addr,
	output cart_bus_pkg::cpu_data_t   bsram_d,
	input  cart_bus_pkg::cpu_data_t   bsram_q,
	output logic                      bsram_ce_n,
	output logic                      bsram_oe_n,
	output logic                      bsram_we_n,

	output cart_bus_pkg::cpu_data_t   map_data,
	output logic                      map_sel
);

	logic                      hirom;
	logic                      lo_sram;
	logic                      hi_sram;
	logic                      sram_hit;
	logic                      rom_hit;
	logic [21:0]               rom_raw;
	logic [19:0]               sram_raw;
	cart_bus_pkg::rom_addr_t   rom_next;
	cart_bus_pkg::bsram_addr_t bsram_next;

	assign hirom = map_ctrl[`CART_MAP_HIROM_BIT];

	assign lo_sram = !hirom && !ca[15] &&
		(ca[23:16] >= `CART_LOROM_SRAM_FIRST) && (ca[23:16] <= `CART_LOROM_SRAM_LAST);
	assign hi_sram = hirom && (ca[22:21] == 2'b01) && (ca[15:13] == 3'b011); // 20-3f/a0-bf:6000-7fff

	assign sram_hit = lo_sram || hi_sram;
	assign rom_hit  = !romsel_n && !sram_hit; // save ram wins

	always_comb begin
		if (hirom) begin
			rom_raw  = ca[21:0];
			sram_raw = {2'b00, ca[20:16], ca[12:0]};
		end else begin
			rom_raw  = {ca[22:16], ca[14:0]}; // a23 and a15 dropped
			sram_raw = {1'b0, ca[19:16], ca[14:0]};
		end
	end

	assign rom_next   = {2'b00, rom_raw} & rom_mask;
	assign bsram_next = sram_raw & bsram_mask;

	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			rom_ce_n   <= 1'b1;
			rom_oe_n   <= 1'b1;
			bsram_ce_n <= 1'b1;
			bsram_oe_n <= 1'b1;
			bsram_we_n <= 1'b1;
			map_sel    <= 1'b0;
		end else begin
			rom_ce_n   <= !rom_hit;
			rom_oe_n   <= !(rom_hit && !cpurd_n);
			bsram_ce_n <= !sram_hit;
			bsram_oe_n <= !(sram_hit && !cpurd_n);
			bsram_we_n <= !(sram_hit && !cpuwr_n);
			map_sel    <= rom_hit || sram_hit;
		end
	end

	always_ff @(posedge mclk) begin
		rom_addr   <= rom_next;
		bsram_addr <= bsram_next;
		bsram_d    <= cpu_wdata;
	end

	// byte lane of the rom word, or the save ram byte
	always_comb begin
		if (!bsram_ce_n) begin
			map_data = bsram_q;
		end else if (rom_addr[0]) begin
			map_data = rom_q[15:8];
		end else begin
			map_data = rom_q[7:0];
		end
	end

endmodule

/* hw/msu_regs.sv */
`include "cart_consts.svh"

module msu_regs (
	input  logic                      mclk,
	input  logic                      rst_n,

	input  cart_bus_pkg::cpu_addr_t   ca,
	input  logic                      cpurd_n,
	input  logic                      cpuwr_n,
	input  cart_bus_pkg::cpu_data_t   cpu_wdata,

	output cart_bus_pkg::cpu_data_t   msu_data,
	output logic                      msu_sel,

	output msu_pkg::msu_addr_t        data_addr,
	output logic                      data_req,
	input  logic                      data_ack,
	input  cart_bus_pkg::cpu_data_t   msu_byte,

	output msu_pkg::msu_track_t       track_num,
	output msu_pkg::msu_volume_t      volume
);

	logic                    hit;
	logic [2:0]              off;
	logic                    cpuwr_q;
	logic                    cpurd_q;
	logic                    wr_first;
	logic                    rd_end;
	logic                    data_rd;
	logic                    seek_pend;
	logic                    adv_pend;
	logic                    busy;
	cart_bus_pkg::cpu_data_t status;
	cart_bus_pkg::cpu_data_t id_byte;
	cart_bus_pkg::cpu_data_t data_byte;
	msu_pkg::msu_addr_t      seek_addr;
	msu_pkg::msu_fetch_t     state;

	// banks 00-3f and 80-bf, 2000-2007
	assign hit = !ca[22] && ((ca[15:0] & 16'hfff8) == `CART_MSU_BASE);
	assign off = ca[2:0];

	assign wr_first = !cpuwr_n && cpuwr_q;
	assign rd_end   = cpurd_n && !cpurd_q;

	assign busy = seek_pend || adv_pend || (state != msu_pkg::FETCH_IDLE);

	always_comb begin
		status = '0;
		status[`CART_STATUS_BUSY_BIT] = busy;
	end

	always_comb begin
		case (off)
			3'd2:    id_byte = `CART_MSU_ID_0;
			3'd3:    id_byte = `CART_MSU_ID_1;
			3'd4:    id_byte = `CART_MSU_ID_2;
			3'd5:    id_byte = `CART_MSU_ID_3;
			3'd6:    id_byte = `CART_MSU_ID_4;
			default: id_byte = `CART_MSU_ID_5;
		endcase
	end

	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			cpuwr_q   <= 1'b1;
			cpurd_q   <= 1'b1;
			msu_sel   <= 1'b0;
			data_rd   <= 1'b0;
			seek_pend <= 1'b0;
			adv_pend  <= 1'b0;
			state     <= msu_pkg::FETCH_IDLE;
			data_req  <= 1'b0;
			data_addr <= '0;
			seek_addr <= '0;
			track_num <= '0;
			volume    <= '0;
		end else begin
			cpuwr_q <= cpuwr_n;
			cpurd_q <= cpurd_n;
			msu_sel <= hit;

			case (state)
				msu_pkg::FETCH_IDLE: begin
					if (seek_pend || adv_pend) begin
						if (seek_pend) begin
							data_addr <= seek_addr;
						end else begin
							data_addr <= data_addr + 32'd1;
						end
						seek_pend <= 1'b0;
						adv_pend  <= 1'b0;
						data_req  <= 1'b1; // addr is valid on the same edge
						state     <= msu_pkg::FETCH_REQ;
					end
				end
				msu_pkg::FETCH_REQ: begin
					if (data_ack) begin
						data_req <= 1'b0;
						state    <= msu_pkg::FETCH_DROP;
					end
				end
				msu_pkg::FETCH_DROP: begin
					if (!data_ack) begin
						state <= msu_pkg::FETCH_IDLE;
					end
				end
				default: state <= msu_pkg::FETCH_IDLE;
			endcase

			// new requests land after the fsm so a set wins over a clear
			if (hit && wr_first) begin
				case (off)
					`CART_MSU_REG_SEEK0:    seek_addr[7:0]   <= cpu_wdata;
					`CART_MSU_REG_SEEK1:    seek_addr[15:8]  <= cpu_wdata;
					`CART_MSU_REG_SEEK2:    seek_addr[23:16] <= cpu_wdata;
					`CART_MSU_REG_SEEK3: begin
						seek_addr[31:24] <= cpu_wdata;
						seek_pend        <= 1'b1;
					end
					`CART_MSU_REG_TRACK_LO: track_num[7:0]   <= cpu_wdata;
					`CART_MSU_REG_TRACK_HI: track_num[15:8]  <= cpu_wdata;
					`CART_MSU_REG_VOLUME:   volume           <= cpu_wdata;
					default: ;
				endcase
			end

			if (rd_end) begin
				data_rd <= 1'b0;
			end else if (hit && !cpurd_n && (off == `CART_MSU_REG_DATA)) begin
				data_rd <= 1'b1;
			end

			if (rd_end && data_rd) begin
				adv_pend <= 1'b1; // step to the next byte
			end
		end
	end

	always_ff @(posedge mclk) begin
		if ((state == msu_pkg::FETCH_REQ) && data_ack) begin
			data_byte <= msu_byte;
		end

		case (off)
			`CART_MSU_REG_STATUS: msu_data <= status;
			`CART_MSU_REG_DATA:   msu_data <= data_byte; // old byte while busy
			default:              msu_data <= id_byte;
		endcase
	end

endmodule

/* hw/cpu_data_mux.sv */
module cpu_data_mux (
	input  logic                    mclk,
	input  logic                    rst_n,

	input  logic                    cpurd_n,

	input  cart_bus_pkg::cpu_data_t map_data,
	input  logic                    map_sel,
	input  cart_bus_pkg::cpu_data_t msu_data,
	input  logic                    msu_sel,

	output cart_bus_pkg::cpu_data_t cpu_rdata
);

	logic                    rd_q;
	logic                    src_ok;
	cart_bus_pkg::cpu_data_t src_data;

	// msu has priority over the cart map
	always_comb begin
		src_ok   = 1'b1;
		src_data = '0;
		if (msu_sel) begin
			src_data = msu_data;
		end else if (map_sel) begin
			src_data = map_data;
		end else begin
			src_ok = 1'b0;
		end
	end

	always_ff @(posedge mclk) begin
		if (!rst_n) begin
			rd_q      <= 1'b0;
			cpu_rdata <= '0;
		end else begin
			rd_q <= !cpurd_n; // lines up with the registered selects
			if (rd_q && src_ok) begin
				cpu_rdata <= src_data;
			end
			// otherwise open bus, last value stays
		end
	end

endmodule

/* hw/cart_top.sv */
module cart_top (
	input  logic                      mclk,
	input  logic                      rst_n,

	input  cart_bus_pkg::cpu_addr_t   ca,
	input  logic                      cpurd_n,
	input  logic                      cpuwr_n,
	input  logic                      romsel_n,
	input  cart_bus_pkg::cpu_data_t   cpu_wdata,
	output cart_bus_pkg::cpu_data_t   cpu_rdata,

	input  cart_bus_pkg::map_ctrl_t   map_ctrl,
	input  cart_bus_pkg::rom_addr_t   rom_mask,
	input  cart_bus_pkg::bsram_addr_t bsram_mask,

	output cart_bus_pkg::rom_addr_t   rom_addr,
	input  cart_bus_pkg::rom_word_t   rom_q,
	output logic                      rom_ce_n,
	output logic                      rom_oe_n,

	output cart_bus_pkg::bsram_addr_t bsram_addr,
	output cart_bus_pkg::cpu_data_t   bsram_d,
	input  cart_bus_pkg::cpu_data_t   bsram_q,
	output logic                      bsram_ce_n,
	output logic                      bsram_oe_n,
	output logic                      bsram_we_n,

	output msu_pkg::msu_addr_t        data_addr,
	output logic                      data_req,
	input  logic                      data_ack,
	input  cart_bus_pkg::cpu_data_t   msu_byte,
	output msu_pkg::msu_track_t       track_num,
	output msu_pkg::msu_volume_t      volume
);

	cart_bus_pkg::cpu_data_t map_data;
	logic                    map_sel;
	cart_bus_pkg::cpu_data_t msu_data;
	logic                    msu_sel;

	rom_mapper rom_mapper (
		.mclk       (mclk),
		.rst_n      (rst_n),
		.ca         (ca),
		.cpurd_n    (cpurd_n),
		.cpuwr_n    (cpuwr_n),
		.romsel_n   (romsel_n),
		.cpu_wdata  (cpu_wdata),
		.map_ctrl   (map_ctrl),
		.rom_mask   (rom_mask),
		.bsram_mask (bsram_mask),
		.rom_addr   (rom_addr),
		.rom_q      (rom_q),
		.rom_ce_n   (rom_ce_n),
		.rom_oe_n   (rom_oe_n),
		.bsram_addr (bsram_addr),
		.bsram_d    (bsram_d),
		.bsram_q    (bsram_q),
		.bsram_ce_n (bsram_ce_n),
		.bsram_oe_n (bsram_oe_n),
		.bsram_we_n (bsram_we_n),
		.map_data   (map_data),
		.map_sel    (map_sel)
	);

	msu_regs msu_regs (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.ca        (ca),
		.cpurd_n   (cpurd_n),
		.cpuwr_n   (cpuwr_n),
		.cpu_wdata (cpu_wdata),
		.msu_data  (msu_data),
		.msu_sel   (msu_sel),
		.data_addr (data_addr),
		.data_req  (data_req),
		.data_ack  (data_ack),
		.msu_byte  (msu_byte),
		.track_num (track_num),
		.volume    (volume)
	);

	cpu_data_mux cpu_data_mux (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.cpurd_n   (cpurd_n),
		.map_data  (map_data),
		.map_sel   (map_sel),
		.msu_data  (msu_data),
		.msu_sel   (msu_sel),
		.cpu_rdata (cpu_rdata)
	);

endmodule

/* sim/tb_cart_top.sv */
module tb_cart_top;

	logic                      mclk;
	logic                      rst_n;
	cart_bus_pkg::cpu_addr_t   ca;
	logic                      cpurd_n;
	logic                      cpuwr_n;
	logic                      romsel_n;
	cart_bus_pkg::cpu_data_t   cpu_wdata;
	cart_bus_pkg::cpu_data_t   cpu_rdata;
	cart_bus_pkg::map_ctrl_t   map_ctrl;
	cart_bus_pkg::rom_addr_t   rom_mask;
	cart_bus_pkg::bsram_addr_t bsram_mask;
	cart_bus_pkg::rom_addr_t   rom_addr;
	cart_bus_pkg::rom_word_t   rom_q;
	logic                      rom_ce_n;
	logic                      rom_oe_n;
	cart_bus_pkg::bsram_addr_t bsram_addr;
	cart_bus_pkg::cpu_data_t   bsram_d;
	cart_bus_pkg::cpu_data_t   bsram_q;
	logic                      bsram_ce_n;
	logic                      bsram_oe_n;
	logic                      bsram_we_n;
	msu_pkg::msu_addr_t        data_addr;
	logic                      data_req;
	logic                      data_ack;
	cart_bus_pkg::cpu_data_t   msu_byte;
	msu_pkg::msu_track_t       track_num;
	msu_pkg::msu_volume_t      volume;

	int   errors = 0;
	int   proto_errors = 0;
	int   watch_errors = 0;
	int   checks = 0;
	logic sram_watch;
	logic [7:0] bsram_mem [0:8191]; // 8k save ram

	localparam logic [47:0] ID_TEXT = "S-MSU1";

	cart_top dut (.*);

	initial begin
		mclk = 1'b0;
		forever #50 mclk = ~mclk;
	end

	function automatic cart_bus_pkg::rom_word_t rom_word(input cart_bus_pkg::rom_addr_t a);
		logic [7:0] hi;
		logic [7:0] lo;
		hi = a[8:1] ^ a[23:16] ^ 8'ha5;
		lo = a[16:9] + a[8:1];
		return {hi, lo};
	endfunction

	function automatic cart_bus_pkg::cpu_data_t rom_byte(input cart_bus_pkg::rom_addr_t a);
		cart_bus_pkg::rom_word_t w;
		w = rom_word(a);
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	// memories answer only while chip and output enable are low
	assign rom_q   = (!rom_ce_n && !rom_oe_n) ? rom_word(rom_addr) : 'x;
	assign bsram_q = (!bsram_ce_n && !bsram_oe_n) ? bsram_mem[bsram_addr[12:0]] : 'x;

	always @(posedge mclk) begin
		if (!bsram_ce_n && !bsram_we_n) begin
			bsram_mem[bsram_addr[12:0]] <= bsram_d;
		end
	end

	// four-phase streamed data source
	initial begin : msu_source
		int unsigned wait_cycles;
		int unsigned hold_cycles;
		logic        req_q;
		data_ack    = 1'b0;
		msu_byte    = '0;
		wait_cycles = 0;
		hold_cycles = 0;
		req_q       = 1'b0;
		forever begin
			@(posedge mclk);
			#10;
			if (data_req && !req_q && data_ack) begin
				proto_errors++;
				$display("data_req rose again while data_ack was still high");
			end
			req_q = data_req;
			if (data_ack) begin
				if (!data_req) begin
					if (hold_cycles != 0) begin
						hold_cycles--; // slow ack release
					end else begin
						data_ack = 1'b0;
					end
				end
			end else if (wait_cycles != 0) begin
				wait_cycles--;
				if (wait_cycles == 0) begin
					msu_byte    = data_addr[7:0] ^ 8'h5a;
					data_ack    = 1'b1;
					hold_cycles = $urandom % 3;
				end
			end else if (data_req) begin
				wait_cycles = 1 + ($urandom % 5);
			end
		end
	end

	initial begin : rom_ce_watch
		forever begin
			@(negedge mclk);
			if (sram_watch && (rom_ce_n !== 1'b1)) begin
				watch_errors++;
				$display("[ERROR] bsram_rom_ce: expected 1, got %b", rom_ce_n);
			end
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		errors++;
		$display("[ERROR] %s: expected %h, got %h", name, exp, act);
	endtask

	task automatic cpu_read(input cart_bus_pkg::cpu_addr_t addr, input logic rsel,
			output cart_bus_pkg::cpu_data_t data);
		@(posedge mclk);
		#10;
		ca       = addr;
		romsel_n = rsel;
		cpurd_n  = 1'b0;
		repeat (3) @(posedge mclk); // data lands 2 cycles after ca
		#10;
		data    = cpu_rdata;
		cpurd_n = 1'b1;
	endtask

	task automatic cpu_write(input cart_bus_pkg::cpu_addr_t addr, input logic rsel,
			input cart_bus_pkg::cpu_data_t data);
		@(posedge mclk);
		#10;
		ca        = addr;
		romsel_n  = rsel;
		cpu_wdata = data;
		cpuwr_n   = 1'b0;
		repeat (2) @(posedge mclk);
		#10;
		cpuwr_n = 1'b1;
		@(posedge mclk);
		#10;
	endtask

	task automatic wait_msu_idle();
		cart_bus_pkg::cpu_data_t status;
		int polls;
		polls  = 0;
		status = 8'h80;
		while (status[7] && (polls < 40)) begin
			cpu_read(24'h002000, 1'b1, status);
			polls++;
		end
		checks++;
		if (status[7]) begin
			errors++;
			$display("timeout: MSU busy bit still set after %0d status reads", polls);
		end
	endtask

	task automatic check_reset_state();
		checks++;
		if ({cpu_rdata, data_req, rom_ce_n, rom_oe_n, bsram_ce_n, bsram_oe_n, bsram_we_n}
				!== {8'h00, 1'b0, 5'b11111}) begin
			report_mismatch("reset", {16'h0, 8'h00, 1'b0, 5'b11111, 2'b00},
				{16'h0, cpu_rdata, data_req, rom_ce_n, rom_oe_n, bsram_ce_n,
				bsram_oe_n, bsram_we_n, 2'b00});
		end
	endtask

	task automatic read_rom_random();
		logic [31:0]             rnd;
		cart_bus_pkg::cpu_addr_t addr;
		cart_bus_pkg::rom_addr_t exp_addr;
		cart_bus_pkg::cpu_data_t got;
		for (int mode = 0; mode < 2; mode++) begin
			map_ctrl = 8'(mode);
			for (int i = 0; i < 8; i++) begin
				rnd = $urandom;
				if (mode == 1) begin
					addr     = {2'b11, rnd[21:0]}; // banks c0-ff stay clear of save ram
					exp_addr = {2'b00, addr[21:0]} & rom_mask;
				end else begin
					addr     = {rnd[23:16], 1'b1, rnd[14:0]};
					exp_addr = {2'b00, addr[22:16], addr[14:0]} & rom_mask;
				end
				cpu_read(addr, 1'b0, got);
				checks++;
				if (got !== rom_byte(exp_addr)) begin
					report_mismatch(mode ? "rom_hirom" : "rom_lorom",
						32'(rom_byte(exp_addr)), 32'(got));
				end
			end
		end
	endtask

	task automatic bsram_write_read();
		cart_bus_pkg::cpu_addr_t lo_addr [3];
		cart_bus_pkg::cpu_addr_t hi_addr [3];
		cart_bus_pkg::cpu_data_t wdata [3];
		cart_bus_pkg::cpu_data_t got;
		logic [31:0]             rnd;
		lo_addr = '{24'h700123, 24'h7b1456, 24'h7d7fff};
		hi_addr = '{24'h206000, 24'hbf7abc, 24'h3a6de0};
		for (int mode = 0; mode < 2; mode++) begin
			map_ctrl = 8'(mode);
			for (int i = 0; i < 3; i++) begin
				rnd      = $urandom;
				wdata[i] = rnd[7:0];
				// romsel_n held low so save ram has to win over rom
				cpu_write((mode == 1) ? hi_addr[i] : lo_addr[i], 1'b0, wdata[i]);
				sram_watch = 1'b1;
			end
			for (int i = 0; i < 3; i++) begin
				cpu_read((mode == 1) ? hi_addr[i] : lo_addr[i], 1'b0, got);
				checks++;
				if (got !== wdata[i]) begin
					report_mismatch("bsram", 32'(wdata[i]), 32'(got));
				end
			end
			sram_watch = 1'b0;
		end
	endtask

	task automatic read_msu_id();
		cart_bus_pkg::cpu_data_t got;
		cart_bus_pkg::cpu_data_t last;
		map_ctrl = 8'h00;
		for (int i = 0; i < 6; i++) begin
			cpu_read(24'h002002 + 24'(i), 1'b1, got);
			checks++;
			if (got !== ID_TEXT[47 - 8*i -: 8]) begin
				report_mismatch("msu_id", 32'(ID_TEXT[47 - 8*i -: 8]), 32'(got));
			end
		end
		cpu_read(24'h802007, 1'b1, got); // upper mirror
		checks++;
		if (got !== ID_TEXT[7:0]) begin
			report_mismatch("msu_id_mirror", 32'(ID_TEXT[7:0]), 32'(got));
		end
		last = got;
		cpu_read(24'h401234, 1'b1, got); // nothing decodes here
		checks++;
		if (got !== last) begin
			report_mismatch("open_bus", 32'(last), 32'(got));
		end
	endtask

	task automatic stream_msu_data();
		logic [31:0]             seek;
		logic [31:0]             pos;
		cart_bus_pkg::cpu_data_t got;
		cart_bus_pkg::cpu_data_t exp;
		seek = $urandom;
		for (int i = 0; i < 4; i++) begin
			cpu_write(24'h002000 + 24'(i), 1'b1, seek[8*i +: 8]);
		end
		for (int n = 0; n < 4; n++) begin
			wait_msu_idle();
			cpu_read(24'h002001, 1'b1, got);
			pos = seek + 32'(n);
			exp = pos[7:0] ^ 8'h5a;
			checks++;
			if (got !== exp) begin
				report_mismatch("msu_data", 32'(exp), 32'(got));
			end
		end
	endtask

	task automatic write_track_volume();
		cpu_write(24'h002004, 1'b1, 8'h34);
		cpu_write(24'h002005, 1'b1, 8'h12);
		cpu_write(24'h002006, 1'b1, 8'hc8);
		checks++;
		if (track_num !== 16'h1234) begin
			report_mismatch("msu_track", 32'h1234, 32'(track_num));
		end
		checks++;
		if (volume !== 8'hc8) begin
			report_mismatch("msu_volume", 32'hc8, 32'(volume));
		end
	endtask

	initial begin
		void'($urandom(32'h3aaa0077));
		rst_n      = 1'b0;
		ca         = '0;
		cpurd_n    = 1'b1;
		cpuwr_n    = 1'b1;
		romsel_n   = 1'b1;
		cpu_wdata  = '0;
		map_ctrl   = '0;
		rom_mask   = 24'h1fffff; // 2 MB rom
		bsram_mask = 20'h01fff;
		sram_watch = 1'b0;
		repeat (3) @(posedge mclk);
		#10;
		rst_n = 1'b1;

		check_reset_state();
		read_rom_random();
		bsram_write_read();
		read_msu_id();
		stream_msu_data();
		write_track_volume();

		errors = errors + proto_errors + watch_errors;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+include
hw/cart_bus_pkg.sv
hw/msu_pkg.sv
hw/rom_mapper.sv
hw/msu_regs.sv
hw/cpu_data_mux.sv
hw/cart_top.sv
sim/tb_cart_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cart_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
